/* logic/pbus_axil_decoder.sv */
/*
 * AXI-lite slave and address decoder of the peripheral bus.
 * Turns accepted transfers into per-slave register strobes and
 * returns the selected read word with OKAY or SLVERR.
 */
module pbus_axil_decoder import pbus_axil_pkg::*, pbus_map_pkg::*; (
    input  logic                                pbus_clock_i,
    input  logic                                arst_n_i,
    input  pbus_axil_req_t                      axil_req_i,
    output pbus_axil_rsp_t                      axil_rsp_o,
    output pbus_reg_req_t [NUM_PBUS_SLAVES-1:0] reg_req_o,
    input  pbus_data_t    [NUM_PBUS_SLAVES-1:0] reg_rdata_i
);

    logic [PBUS_SLAVE_SEL_WIDTH-1:0] aw_sel;
    logic [PBUS_SLAVE_SEL_WIDTH-1:0] ar_sel;
    logic                            aw_legal;
    logic                            ar_legal;
    logic                            wr_accept;
    logic                            rd_accept;
    logic                            bvalid_q;
    logic                            rvalid_q;
    pbus_resp_t                      bresp_q;
    pbus_resp_t                      rresp_q;
    pbus_data_t                      rdata_q;

    //////////////////////////////
    // address decode
    //////////////////////////////
    assign aw_sel = axil_req_i.awaddr[PBUS_SLAVE_SEL_LSB +: PBUS_SLAVE_SEL_WIDTH];
    assign ar_sel = axil_req_i.araddr[PBUS_SLAVE_SEL_LSB +: PBUS_SLAVE_SEL_WIDTH];

    // nothing mapped above the slave select bits
    assign aw_legal = (axil_req_i.awaddr[PBUS_ADDR_WIDTH-1:PBUS_SLAVE_SEL_LSB+PBUS_SLAVE_SEL_WIDTH]
                       == '0);
    assign ar_legal = (axil_req_i.araddr[PBUS_ADDR_WIDTH-1:PBUS_SLAVE_SEL_LSB+PBUS_SLAVE_SEL_WIDTH]
                       == '0);

    assign wr_accept = axil_req_i.awvalid & axil_req_i.wvalid & ~bvalid_q;  // aw and w together
    assign rd_accept = axil_req_i.arvalid & ~rvalid_q;                      // one read in flight

    // strobes reach every slave but only the addressed one sees wr_en
    always_comb begin
        for (int s = 0; s < NUM_PBUS_SLAVES; s++) begin
            reg_req_o[s].wr_en   = wr_accept & aw_legal &
                                   (aw_sel == PBUS_SLAVE_SEL_WIDTH'(s));
            reg_req_o[s].wr_word = axil_req_i.awaddr[PBUS_REG_WORD_LSB +: PBUS_REG_WORD_WIDTH];
            reg_req_o[s].rd_word = axil_req_i.araddr[PBUS_REG_WORD_LSB +: PBUS_REG_WORD_WIDTH];
            reg_req_o[s].wdata   = axil_req_i.wdata;
            reg_req_o[s].wstrb   = axil_req_i.wstrb;
        end
    end

    //////////////////////////////
    // response channels
    //////////////////////////////
    always_ff @(posedge pbus_clock_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            bvalid_q <= 1'b0;
            bresp_q  <= PBUS_RESP_OKAY;
            rvalid_q <= 1'b0;
            rresp_q  <= PBUS_RESP_OKAY;
        end else begin
            if (wr_accept) begin
                bvalid_q <= 1'b1;
                bresp_q  <= aw_legal ? PBUS_RESP_OKAY : PBUS_RESP_SLVERR;
            end else if (axil_req_i.bready) begin
                bvalid_q <= 1'b0;                   // b handshake done
            end
            if (rd_accept) begin
                rvalid_q <= 1'b1;
                rresp_q  <= ar_legal ? PBUS_RESP_OKAY : PBUS_RESP_SLVERR;
            end else if (axil_req_i.rready) begin
                rvalid_q <= 1'b0;                   // r handshake done
            end
        end
    end

    // read word sampled at accept before any same-cycle write lands
    always_ff @(posedge pbus_clock_i or negedge arst_n_i) begin
        if (!arst_n_i)
            rdata_q <= '0;
        else if (rd_accept)
            rdata_q <= ar_legal ? reg_rdata_i[ar_sel] : '0;
    end

    always_comb begin
        axil_rsp_o.awready = wr_accept;
        axil_rsp_o.wready  = wr_accept;
        axil_rsp_o.bresp   = bresp_q;
        axil_rsp_o.bvalid  = bvalid_q;
        axil_rsp_o.arready = rd_accept;
        axil_rsp_o.rdata   = rdata_q;
        axil_rsp_o.rresp   = rresp_q;
        axil_rsp_o.rvalid  = rvalid_q;
    end

endmodule : pbus_axil_decoder

/* logic/pbus_axil_pkg.sv */
/*
 * Peripheral bus, bus-side definitions.
 * AXI-lite channel bundles, register strobe bundle and response codes.
 */
package pbus_axil_pkg;

    localparam int unsigned PBUS_DATA_WIDTH     = 32;
    localparam int unsigned PBUS_ADDR_WIDTH     = 32;
    localparam int unsigned PBUS_STRB_WIDTH     = PBUS_DATA_WIDTH / 8;
    localparam int unsigned PBUS_REG_WORD_LSB   = 2;    // word select starts above byte offset
    localparam int unsigned PBUS_REG_WORD_WIDTH = 2;    // four words per peripheral

    typedef logic [PBUS_DATA_WIDTH-1:0]     pbus_data_t;
    typedef logic [PBUS_ADDR_WIDTH-1:0]     pbus_addr_t;
    typedef logic [PBUS_STRB_WIDTH-1:0]     pbus_strb_t;
    typedef logic [PBUS_REG_WORD_WIDTH-1:0] pbus_word_t;
    typedef logic [1:0]                     pbus_resp_t;

    localparam pbus_resp_t PBUS_RESP_OKAY   = 2'd0;
    localparam pbus_resp_t PBUS_RESP_SLVERR = 2'd2;

    // master side of the AXI-lite port
    typedef struct packed {
        pbus_addr_t awaddr;
        logic       awvalid;
        pbus_data_t wdata;
        pbus_strb_t wstrb;
        logic       wvalid;
        logic       bready;
        pbus_addr_t araddr;
        logic       arvalid;
        logic       rready;
    } pbus_axil_req_t;

    // slave side of the AXI-lite port
    typedef struct packed {
        logic       awready;
        logic       wready;
        pbus_resp_t bresp;
        logic       bvalid;
        logic       arready;
        pbus_data_t rdata;
        pbus_resp_t rresp;
        logic       rvalid;
    } pbus_axil_rsp_t;

    // decoder to peripheral register access
    typedef struct packed {
        logic       wr_en;      // single cycle write pulse
        pbus_word_t wr_word;
        pbus_word_t rd_word;    // shared by all slaves
        pbus_data_t wdata;
        pbus_strb_t wstrb;
    } pbus_reg_req_t;

    // byte lane merge of a write into an existing word
    function automatic pbus_data_t pbus_strb_merge(pbus_data_t old_word,
                                                   pbus_data_t new_word,
                                                   pbus_strb_t strb);
        pbus_data_t merged;
        merged = old_word;
        for (int b = 0; b < PBUS_STRB_WIDTH; b++) begin
            if (strb[b])
                merged[8*b +: 8] = new_word[8*b +: 8];  // lane enabled
        end
        return merged;
    endfunction

endpackage : pbus_axil_pkg

/* logic/pbus_gpio_in.sv */
/*
 * GPIO input block.
 * Two-flop pin synchronizer, change detect and a sticky change interrupt.
 */
module pbus_gpio_in import pbus_axil_pkg::*, pbus_map_pkg::*; (
    input  logic                   pbus_clock_i,
    input  logic                   arst_n_i,
    input  pbus_reg_req_t          reg_req_i,
    output pbus_data_t             reg_rdata_o,
    input  logic [NUM_GPIO_IN-1:0] gpio_in_i,
    output logic                   irq_o
);

    logic [NUM_GPIO_IN-1:0] sync_meta_q;   // first stage that may go metastable
    logic [NUM_GPIO_IN-1:0] sync_q;        // DATA register value
    logic [NUM_GPIO_IN-1:0] prev_q;
    logic                   irq_en_q;
    logic                   status_q;
    logic                   pin_change;
    logic                   status_clr;
    pbus_data_t             en_merged;

    assign pin_change = (sync_q != prev_q);
    assign status_clr = reg_req_i.wr_en & (reg_req_i.wr_word == GPIO_IRQ_STATUS_REG) &
                        reg_req_i.wstrb[0] & reg_req_i.wdata[0];    // w1c
    assign en_merged  = pbus_strb_merge(pbus_data_t'(irq_en_q), reg_req_i.wdata, reg_req_i.wstrb);

    always_ff @(posedge pbus_clock_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            sync_meta_q <= '0;
            sync_q      <= '0;
            prev_q      <= '0;
            irq_en_q    <= 1'b0;
            status_q    <= 1'b0;
        end else begin
            sync_meta_q <= gpio_in_i;
            sync_q      <= sync_meta_q;
            prev_q      <= sync_q;
            if (reg_req_i.wr_en && reg_req_i.wr_word == GPIO_IRQ_EN_REG)
                irq_en_q <= en_merged[0];
            // a change in the same cycle as the clear keeps the flag
            status_q    <= (status_q & ~status_clr) | (pin_change & irq_en_q);
        end
    end

    assign irq_o = status_q;

    always_comb begin
        case (reg_req_i.rd_word)
            GPIO_DATA_REG:       reg_rdata_o = pbus_data_t'(sync_q);
            GPIO_IRQ_EN_REG:     reg_rdata_o = pbus_data_t'(irq_en_q);
            GPIO_IRQ_STATUS_REG: reg_rdata_o = pbus_data_t'(status_q);
            default:             reg_rdata_o = '0;   // unmapped word
        endcase
    end

endmodule : pbus_gpio_in

/* logic/pbus_gpio_out.sv */
/*
 * GPIO output block, one data register driving the pins.
 */
module pbus_gpio_out import pbus_axil_pkg::*, pbus_map_pkg::*; (
    input  logic                    pbus_clock_i,
    input  logic                    arst_n_i,
    input  pbus_reg_req_t           reg_req_i,
    output pbus_data_t              reg_rdata_o,
    output logic [NUM_GPIO_OUT-1:0] gpio_out_o
);

    logic [NUM_GPIO_OUT-1:0] data_q;
    pbus_data_t              data_merged;

    assign data_merged = pbus_strb_merge(pbus_data_t'(data_q), reg_req_i.wdata, reg_req_i.wstrb);

    always_ff @(posedge pbus_clock_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            data_q <= '0;
        end else if (reg_req_i.wr_en && reg_req_i.wr_word == GPIO_DATA_REG) begin
            data_q <= data_merged[NUM_GPIO_OUT-1:0];   // byte lanes honored
        end
    end

    assign gpio_out_o = data_q;     // pins follow the register

    // only the data word is mapped
    assign reg_rdata_o = (reg_req_i.rd_word == GPIO_DATA_REG) ? pbus_data_t'(data_q) : '0;

endmodule : pbus_gpio_out

/* logic/pbus_map_pkg.sv */
/*
 * Peripheral bus address map and peripheral layout.
 * Slave windows, register offsets, control bits and interrupt slots.
 */
package pbus_map_pkg;

    // 4 KB windows selected by addr[13:12]
    localparam int unsigned NUM_PBUS_SLAVES      = 4;
    localparam int unsigned PBUS_SLAVE_SEL_LSB   = 12;
    localparam int unsigned PBUS_SLAVE_SEL_WIDTH = 2;

    localparam int unsigned PBUS_GPIO_OUT_IDX = 0;
    localparam int unsigned PBUS_GPIO_IN_IDX  = 1;
    localparam int unsigned PBUS_TIM0_IDX     = 2;
    localparam int unsigned PBUS_TIM1_IDX     = 3;

    // gpio register words
    localparam logic [1:0] GPIO_DATA_REG       = 2'd0;
    localparam logic [1:0] GPIO_IRQ_EN_REG     = 2'd1;
    localparam logic [1:0] GPIO_IRQ_STATUS_REG = 2'd2;

    // timer register words
    localparam logic [1:0] TIM_CTRL_REG   = 2'd0;
    localparam logic [1:0] TIM_LOAD_REG   = 2'd1;
    localparam logic [1:0] TIM_COUNT_REG  = 2'd2;
    localparam logic [1:0] TIM_STATUS_REG = 2'd3;

    localparam int unsigned TIM_CTRL_WIDTH      = 3;
    localparam int unsigned TIM_CTRL_ENABLE_BIT = 0;
    localparam int unsigned TIM_CTRL_RELOAD_BIT = 1;
    localparam int unsigned TIM_CTRL_IRQ_EN_BIT = 2;

    localparam int unsigned NUM_GPIO_OUT = 8;
    localparam int unsigned NUM_GPIO_IN  = 8;

    // slots in int_o
    localparam int unsigned NUM_IRQ               = 3;
    localparam int unsigned PBUS_GPIOIN_INTERRUPT = 0;
    localparam int unsigned PBUS_TIM0_INTERRUPT   = 1;
    localparam int unsigned PBUS_TIM1_INTERRUPT   = 2;

endpackage : pbus_map_pkg

/* logic/pbus_timer.sv */
/*
 * Down-counting timer with load, optional auto-reload
 * and a sticky expiry flag driving the interrupt.
 */
module pbus_timer import pbus_axil_pkg::*, pbus_map_pkg::*; (
    input  logic          pbus_clock_i,
    input  logic          arst_n_i,
    input  pbus_reg_req_t reg_req_i,
    output pbus_data_t    reg_rdata_o,
    output logic          irq_o
);

    logic [TIM_CTRL_WIDTH-1:0] ctrl_q;
    logic [TIM_CTRL_WIDTH-1:0] ctrl_d;
    pbus_data_t                load_q;
    pbus_data_t                load_d;
    pbus_data_t                count_q;
    pbus_data_t                count_d;
    logic                      expired_q;
    logic                      expired_d;
    logic                      expire_set;
    logic                      status_clr;
    pbus_data_t                ctrl_merged;
    logic                      irq_q;

    assign ctrl_merged = pbus_strb_merge(pbus_data_t'(ctrl_q), reg_req_i.wdata, reg_req_i.wstrb);
    assign expire_set  = ctrl_q[TIM_CTRL_ENABLE_BIT] & (count_q == '0);
    assign status_clr  = reg_req_i.wr_en & (reg_req_i.wr_word == TIM_STATUS_REG) &
                         reg_req_i.wstrb[0] & reg_req_i.wdata[0];   // w1c

    always_comb begin
        ctrl_d  = ctrl_q;
        load_d  = load_q;
        count_d = count_q;
        if (ctrl_q[TIM_CTRL_ENABLE_BIT]) begin
            if (count_q != '0)
                count_d = count_q - 1'b1;           // running
            else if (ctrl_q[TIM_CTRL_RELOAD_BIT])
                count_d = load_q;                   // periodic mode
            else
                ctrl_d[TIM_CTRL_ENABLE_BIT] = 1'b0; // one-shot stops
        end
        // software writes take priority over the count
        if (reg_req_i.wr_en && reg_req_i.wr_word == TIM_CTRL_REG)
            ctrl_d = ctrl_merged[TIM_CTRL_WIDTH-1:0];
        if (reg_req_i.wr_en && reg_req_i.wr_word == TIM_LOAD_REG) begin
            load_d  = pbus_strb_merge(load_q, reg_req_i.wdata, reg_req_i.wstrb);
            count_d = load_d;                       // load also restarts count
        end
        expired_d = (expired_q & ~status_clr) | expire_set;    // new expiry wins
    end

    always_ff @(posedge pbus_clock_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            ctrl_q    <= '0;
            load_q    <= '0;
            count_q   <= '0;
            expired_q <= 1'b0;
            irq_q     <= 1'b0;
        end else begin
            ctrl_q    <= ctrl_d;
            load_q    <= load_d;
            count_q   <= count_d;
            expired_q <= expired_d;
            irq_q     <= expired_d & ctrl_d[TIM_CTRL_IRQ_EN_BIT];
        end
    end

    assign irq_o = irq_q;

    always_comb begin
        case (reg_req_i.rd_word)
            TIM_CTRL_REG:  reg_rdata_o = pbus_data_t'(ctrl_q);
            TIM_LOAD_REG:  reg_rdata_o = load_q;
            TIM_COUNT_REG: reg_rdata_o = count_q;
            default:       reg_rdata_o = pbus_data_t'(expired_q);   // status word
        endcase
    end

endmodule : pbus_timer

/* logic/peripheral_bus.sv */
/*
 * Peripheral bus top level.
 * AXI-lite decoder feeding GPIO out, GPIO in and two timers,
 * with the peripheral interrupts gathered into int_o.
 */
module peripheral_bus import pbus_axil_pkg::*, pbus_map_pkg::*; (
    input  logic                        pbus_clock_i,
    input  logic                        arst_n_i,
    input  pbus_axil_req_t              axil_req_i,     // from the bus master
    output pbus_axil_rsp_t              axil_rsp_o,
    input  logic [NUM_GPIO_IN-1:0]      gpio_in_i,
    output logic [NUM_GPIO_OUT-1:0]     gpio_out_o,
    output logic [NUM_IRQ-1:0]          int_o
);

    pbus_reg_req_t [NUM_PBUS_SLAVES-1:0] reg_req;      // one strobe bundle per slave
    pbus_data_t    [NUM_PBUS_SLAVES-1:0] reg_rdata;    // read words back to decoder

    logic gpio_in_int;
    logic tim0_int;
    logic tim1_int;

    //////////////////////////////
    // decoder
    //////////////////////////////
    pbus_axil_decoder decoder_u (
        .pbus_clock_i   ( pbus_clock_i ),
        .arst_n_i       ( arst_n_i     ),
        .axil_req_i     ( axil_req_i   ),
        .axil_rsp_o     ( axil_rsp_o   ),
        .reg_req_o      ( reg_req      ),
        .reg_rdata_i    ( reg_rdata    )
    );

    //////////////////////////////
    // peripherals
    //////////////////////////////
    pbus_gpio_out gpio_out_u (
        .pbus_clock_i   ( pbus_clock_i                 ),
        .arst_n_i       ( arst_n_i                     ),
        .reg_req_i      ( reg_req[PBUS_GPIO_OUT_IDX]   ),
        .reg_rdata_o    ( reg_rdata[PBUS_GPIO_OUT_IDX] ),
        .gpio_out_o     ( gpio_out_o                   )
    );

    pbus_gpio_in gpio_in_u (
        .pbus_clock_i   ( pbus_clock_i                ),
        .arst_n_i       ( arst_n_i                    ),
        .reg_req_i      ( reg_req[PBUS_GPIO_IN_IDX]   ),
        .reg_rdata_o    ( reg_rdata[PBUS_GPIO_IN_IDX] ),
        .gpio_in_i      ( gpio_in_i                   ),
        .irq_o          ( gpio_in_int                 )
    );

    pbus_timer tim0_u (
        .pbus_clock_i   ( pbus_clock_i             ),
        .arst_n_i       ( arst_n_i                 ),
        .reg_req_i      ( reg_req[PBUS_TIM0_IDX]   ),
        .reg_rdata_o    ( reg_rdata[PBUS_TIM0_IDX] ),
        .irq_o          ( tim0_int                 )
    );

    pbus_timer tim1_u (
        .pbus_clock_i   ( pbus_clock_i             ),
        .arst_n_i       ( arst_n_i                 ),
        .reg_req_i      ( reg_req[PBUS_TIM1_IDX]   ),
        .reg_rdata_o    ( reg_rdata[PBUS_TIM1_IDX] ),
        .irq_o          ( tim1_int                 )
    );

    // interrupt vector from already registered sources
    always_comb begin
        int_o                        = '0;
        int_o[PBUS_GPIOIN_INTERRUPT] = gpio_in_int;
        int_o[PBUS_TIM0_INTERRUPT]   = tim0_int;
        int_o[PBUS_TIM1_INTERRUPT]   = tim1_int;
    end

endmodule : peripheral_bus

/* peripheral_bus.f */
+incdir+verification
logic/pbus_axil_pkg.sv
logic/pbus_map_pkg.sv
logic/pbus_gpio_out.sv
logic/pbus_gpio_in.sv
logic/pbus_timer.sv
logic/pbus_axil_decoder.sv
logic/peripheral_bus.sv
verification/tb_peripheral_bus.sv

/* verification/tb_pbus_model.svh */
/*
 * Peripheral bus testbench helpers.
 * AXI-lite master tasks, register model and compare tasks.
 */
`ifndef TB_PBUS_MODEL_SVH
`define TB_PBUS_MODEL_SVH

//////////////////////////////
// register model
//////////////////////////////
logic [NUM_GPIO_OUT-1:0] gpio_out_m;
logic [NUM_GPIO_IN-1:0]  gpio_in_m;         // value held on the pins
logic                    gpio_irq_en_m;
logic                    gpio_status_m;
pbus_data_t              tim_ctrl_m   [2];
pbus_data_t              tim_load_m   [2];
pbus_data_t              tim_count_m  [2];  // only valid while stopped
logic                    tim_status_m [2];

task automatic reset_model();
    gpio_out_m    = '0;
    gpio_in_m     = '0;
    gpio_irq_en_m = 1'b0;
    gpio_status_m = 1'b0;
    for (int t = 0; t < 2; t++) begin
        tim_ctrl_m[t]   = '0;
        tim_load_m[t]   = '0;
        tim_count_m[t]  = '0;
        tim_status_m[t] = 1'b0;
    end
endtask

function automatic int unsigned tim_idx(input int unsigned t);
    return (t == 0) ? PBUS_TIM0_IDX : PBUS_TIM1_IDX;
endfunction

function automatic int unsigned tim_irq(input int unsigned t);
    return (t == 0) ? PBUS_TIM0_INTERRUPT : PBUS_TIM1_INTERRUPT;
endfunction

// interrupt vector the model predicts
function automatic logic [NUM_IRQ-1:0] expected_irq();
    logic [NUM_IRQ-1:0] v;
    v                        = '0;
    v[PBUS_GPIOIN_INTERRUPT] = gpio_status_m;
    v[PBUS_TIM0_INTERRUPT]   = tim_status_m[0] & tim_ctrl_m[0][TIM_CTRL_IRQ_EN_BIT];
    v[PBUS_TIM1_INTERRUPT]   = tim_status_m[1] & tim_ctrl_m[1][TIM_CTRL_IRQ_EN_BIT];
    return v;
endfunction

function automatic pbus_addr_t reg_addr(input int unsigned slave, input pbus_word_t word);
    return (pbus_addr_t'(slave) << PBUS_SLAVE_SEL_LSB) |
           (pbus_addr_t'(word) << PBUS_REG_WORD_LSB);
endfunction

//////////////////////////////
// compare tasks
//////////////////////////////
task automatic report_failure(input string what);
    $display("%s", what);
    $display("TEST FAILED");
    $fatal(1);
endtask

task automatic check_data(input string name, input pbus_data_t got, input pbus_data_t exp);
    if (got !== exp)
        report_failure($sformatf("[FAIL] %s: got 0x%h, expected 0x%h", name, got, exp));
endtask

task automatic check_resp(input string name, input pbus_resp_t got, input pbus_resp_t exp);
    if (got !== exp)
        report_failure($sformatf("[FAIL] %s: got 0x%h, expected 0x%h", name, got, exp));
endtask

task automatic check_irq(input string name, input logic [NUM_IRQ-1:0] got,
                         input logic [NUM_IRQ-1:0] exp);
    if (got !== exp)
        report_failure($sformatf("[FAIL] %s: got 0x%h, expected 0x%h", name, got, exp));
endtask

task automatic check_bound(input string name, input pbus_data_t got, input pbus_data_t limit);
    if (got > limit)
        report_failure($sformatf("[FAIL] %s: got 0x%h, above limit 0x%h", name, got, limit));
endtask

//////////////////////////////
// AXI-lite master
//////////////////////////////
task automatic axil_write(input pbus_addr_t addr, input pbus_data_t data,
                          input pbus_strb_t strb, output pbus_resp_t resp);
    int unsigned stall;
    stall = $urandom_range(3);                  // bready back-pressure
    @(posedge clk);
    axil_req.awaddr  <= addr;
    axil_req.awvalid <= 1'b1;
    axil_req.wdata   <= data;
    axil_req.wstrb   <= strb;
    axil_req.wvalid  <= 1'b1;
    do @(negedge clk); while (!(axil_rsp.awready && axil_rsp.wready));
    @(posedge clk);                             // aw and w taken here
    axil_req.awvalid <= 1'b0;
    axil_req.wvalid  <= 1'b0;
    repeat (stall) @(posedge clk);
    axil_req.bready  <= 1'b1;
    do @(negedge clk); while (!axil_rsp.bvalid);
    resp = axil_rsp.bresp;
    @(posedge clk);                             // b handshake
    axil_req.bready  <= 1'b0;
endtask

task automatic axil_read(input pbus_addr_t addr, output pbus_data_t data,
                         output pbus_resp_t resp);
    int unsigned stall;
    stall = $urandom_range(3);                  // rready back-pressure
    @(posedge clk);
    axil_req.araddr  <= addr;
    axil_req.arvalid <= 1'b1;
    do @(negedge clk); while (!axil_rsp.arready);
    @(posedge clk);                             // ar taken here
    axil_req.arvalid <= 1'b0;
    repeat (stall) @(posedge clk);
    axil_req.rready  <= 1'b1;
    do @(negedge clk); while (!axil_rsp.rvalid);
    data = axil_rsp.rdata;
    resp = axil_rsp.rresp;
    @(posedge clk);                             // r handshake
    axil_req.rready  <= 1'b0;
endtask

// legal register access expecting OKAY
task automatic write_reg(input int unsigned slave, input pbus_word_t word,
                         input pbus_data_t data, input pbus_strb_t strb);
    pbus_resp_t resp;
    axil_write(reg_addr(slave, word), data, strb, resp);
    check_resp("bresp", resp, PBUS_RESP_OKAY);
endtask

task automatic expect_reg(input int unsigned slave, input pbus_word_t word,
                          input pbus_data_t exp, input string name);
    pbus_data_t data;
    pbus_resp_t resp;
    axil_read(reg_addr(slave, word), data, resp);
    check_resp({name, " rresp"}, resp, PBUS_RESP_OKAY);
    check_data(name, data, exp);
endtask

// every mapped register against the model while the timers are stopped
task automatic verify_all_regs();
    expect_reg(PBUS_GPIO_OUT_IDX, GPIO_DATA_REG, pbus_data_t'(gpio_out_m), "gpio_out DATA");
    expect_reg(PBUS_GPIO_IN_IDX, GPIO_DATA_REG, pbus_data_t'(gpio_in_m), "gpio_in DATA");
    expect_reg(PBUS_GPIO_IN_IDX, GPIO_IRQ_EN_REG, pbus_data_t'(gpio_irq_en_m),
               "gpio_in IRQ_EN");
    expect_reg(PBUS_GPIO_IN_IDX, GPIO_IRQ_STATUS_REG, pbus_data_t'(gpio_status_m),
               "gpio_in IRQ_STATUS");
    for (int t = 0; t < 2; t++) begin
        expect_reg(tim_idx(t), TIM_CTRL_REG, tim_ctrl_m[t], "timer CTRL");
        expect_reg(tim_idx(t), TIM_LOAD_REG, tim_load_m[t], "timer LOAD");
        expect_reg(tim_idx(t), TIM_COUNT_REG, tim_count_m[t], "timer COUNT");
        expect_reg(tim_idx(t), TIM_STATUS_REG, pbus_data_t'(tim_status_m[t]), "timer STATUS");
    end
endtask

`endif

/* verification/tb_peripheral_bus.sv */
/*
 * Peripheral bus testbench.
 * Random AXI-lite traffic to the GPIO blocks and timers, checked against a register model.
 */
module tb_peripheral_bus import pbus_axil_pkg::*, pbus_map_pkg::*; ();

    localparam int CLK_PERIOD    = 20;
    localparam int N_OUT_WRITES  = 16;
    localparam int N_ILLEGAL     = 16;
    localparam int N_PIN_STEPS   = 8;
    localparam int N_COUNT_READS = 8;
    localparam int MAX_LOAD      = 200;     // one-shot load range 5..MAX_LOAD
    localparam int RELOAD_MIN    = 24;      // period longer than a full write access
    localparam int RELOAD_MAX    = 60;

    // bus accesses per sequence starting with the reset check
    localparam int ACCESS_COUNT = 12 + 2*N_OUT_WRITES + (N_ILLEGAL + 12) +
                                  (4*N_PIN_STEPS + 1) + (2*6 + 12) + (7 + N_COUNT_READS);
    localparam int WATCHDOG_CYCLES = ACCESS_COUNT*10 + 2*MAX_LOAD + 3*RELOAD_MAX + 200;

    logic                    clk;
    logic                    arst_n;
    pbus_axil_req_t          axil_req;
    pbus_axil_rsp_t          axil_rsp;
    logic [NUM_GPIO_IN-1:0]  gpio_in;
    logic [NUM_GPIO_OUT-1:0] gpio_out;
    logic [NUM_IRQ-1:0]      irq;
    int unsigned             seed;

    peripheral_bus i_peripheral_bus (
        .pbus_clock_i   ( clk      ),
        .arst_n_i       ( arst_n   ),
        .axil_req_i     ( axil_req ),
        .axil_rsp_o     ( axil_rsp ),
        .gpio_in_i      ( gpio_in  ),
        .gpio_out_o     ( gpio_out ),
        .int_o          ( irq      )
    );

    `include "tb_pbus_model.svh"

    task automatic wait_irq(input int unsigned bit_idx, input int unsigned max_cycles);
        int unsigned n;
        n = 0;
        @(negedge clk);
        while (!irq[bit_idx] && n < max_cycles) begin
            @(negedge clk);
            n++;
        end
        if (!irq[bit_idx])
            report_failure($sformatf("interrupt %0d did not rise within %0d cycles",
                                     bit_idx, max_cycles));
    endtask

    //////////////////////////////
    // sequences
    //////////////////////////////
    task automatic run_gpio_out_test();
        pbus_data_t data;
        pbus_strb_t strb;
        for (int i = 0; i < N_OUT_WRITES; i++) begin
            data = $urandom;
            strb = $urandom_range(15);
            write_reg(PBUS_GPIO_OUT_IDX, GPIO_DATA_REG, data, strb);
            if (strb[0])
                gpio_out_m = data[NUM_GPIO_OUT-1:0];    // pins live in byte lane 0
            @(negedge clk);
            check_data("gpio_out_o", pbus_data_t'(gpio_out), pbus_data_t'(gpio_out_m));
            expect_reg(PBUS_GPIO_OUT_IDX, GPIO_DATA_REG, pbus_data_t'(gpio_out_m),
                       "gpio_out DATA");
        end
    endtask

    task automatic run_illegal_test();
        pbus_addr_t  addr;
        pbus_data_t  data;
        pbus_resp_t  resp;
        pbus_resp_t  exp_resp;
        int unsigned kind;
        for (int i = 0; i < N_ILLEGAL; i++) begin
            kind = $urandom_range(3);   // 0/1 illegal wr/rd, 2/3 unused wr/rd
            if (kind < 2) begin
                addr     = $urandom | (32'h1 << (14 + $urandom_range(17)));
                exp_resp = PBUS_RESP_SLVERR;
            end else begin
                if ($urandom_range(1) == 0)
                    addr = reg_addr(PBUS_GPIO_OUT_IDX, pbus_word_t'($urandom_range(3, 1)));
                else
                    addr = reg_addr(PBUS_GPIO_IN_IDX, 2'd3);
                addr     = addr | ($urandom & 32'h0000_0FF3);  // ignored low bits
                exp_resp = PBUS_RESP_OKAY;
            end
            if (kind % 2 == 0) begin
                axil_write(addr, $urandom, pbus_strb_t'($urandom), resp);
                check_resp("bresp", resp, exp_resp);
            end else begin
                axil_read(addr, data, resp);
                check_resp("rresp", resp, exp_resp);
                check_data("rdata", data, '0);
            end
        end
        verify_all_regs();              // nothing may have moved
    endtask

    task automatic run_gpio_in_test();
        logic [NUM_GPIO_IN-1:0] pins;
        logic [NUM_GPIO_IN-1:0] flip;
        logic                   en;
        for (int i = 0; i < N_PIN_STEPS; i++) begin
            en = $urandom_range(1);
            write_reg(PBUS_GPIO_IN_IDX, GPIO_IRQ_EN_REG, pbus_data_t'(en), 4'hF);
            gpio_irq_en_m = en;
            flip = $urandom_range((1 << NUM_GPIO_IN) - 1, 1);   // never zero
            pins = gpio_in_m ^ flip;
            @(posedge clk);
            gpio_in <= pins;
            repeat (4) @(posedge clk);          // two sync stages and the change detect
            gpio_in_m = pins;
            if (en)
                gpio_status_m = 1'b1;
            @(negedge clk);
            check_irq("int_o", irq, expected_irq());
            expect_reg(PBUS_GPIO_IN_IDX, GPIO_DATA_REG, pbus_data_t'(pins), "gpio_in DATA");
            expect_reg(PBUS_GPIO_IN_IDX, GPIO_IRQ_STATUS_REG, pbus_data_t'(gpio_status_m),
                       "gpio_in IRQ_STATUS");
            if (gpio_status_m) begin
                write_reg(PBUS_GPIO_IN_IDX, GPIO_IRQ_STATUS_REG, 32'h1, 4'h1);     // w1c
                gpio_status_m = 1'b0;
                @(negedge clk);
                check_irq("int_o", irq, expected_irq());
            end
        end
        write_reg(PBUS_GPIO_IN_IDX, GPIO_IRQ_EN_REG, '0, 4'hF);
        gpio_irq_en_m = 1'b0;
    endtask

    task automatic run_oneshot_test();
        pbus_data_t load;
        pbus_data_t ctrl;
        for (int t = 0; t < 2; t++) begin
            load                      = $urandom_range(MAX_LOAD, 5);
            ctrl                      = '0;
            ctrl[TIM_CTRL_ENABLE_BIT] = 1'b1;
            ctrl[TIM_CTRL_IRQ_EN_BIT] = 1'b1;
            write_reg(tim_idx(t), TIM_LOAD_REG, load, 4'hF);
            write_reg(tim_idx(t), TIM_CTRL_REG, ctrl, 4'hF);
            wait_irq(tim_irq(t), MAX_LOAD + 10);
            // one-shot stops at zero with enable dropped
            ctrl[TIM_CTRL_ENABLE_BIT] = 1'b0;
            tim_ctrl_m[t]   = ctrl;
            tim_load_m[t]   = load;
            tim_count_m[t]  = '0;
            tim_status_m[t] = 1'b1;
            check_irq("int_o", irq, expected_irq());    // other timer stays quiet
            expect_reg(tim_idx(t), TIM_COUNT_REG, '0, "timer COUNT");
            expect_reg(tim_idx(t), TIM_CTRL_REG, ctrl, "timer CTRL");
            expect_reg(tim_idx(t), TIM_STATUS_REG, 32'h1, "timer STATUS");
            write_reg(tim_idx(t), TIM_STATUS_REG, 32'h1, 4'h1);
            tim_status_m[t] = 1'b0;
            @(negedge clk);
            check_irq("int_o", irq, expected_irq());
        end
        verify_all_regs();
    endtask

    task automatic run_reload_test();
        pbus_data_t load;
        pbus_data_t ctrl;
        pbus_data_t count;
        pbus_resp_t resp;
        load                      = $urandom_range(RELOAD_MAX, RELOAD_MIN);
        ctrl                      = '0;
        ctrl[TIM_CTRL_ENABLE_BIT] = 1'b1;
        ctrl[TIM_CTRL_RELOAD_BIT] = 1'b1;
        ctrl[TIM_CTRL_IRQ_EN_BIT] = 1'b1;
        write_reg(PBUS_TIM0_IDX, TIM_LOAD_REG, load, 4'hF);
        write_reg(PBUS_TIM0_IDX, TIM_CTRL_REG, ctrl, 4'hF);
        tim_ctrl_m[0] = ctrl;
        tim_load_m[0] = load;
        for (int i = 0; i < N_COUNT_READS; i++) begin
            axil_read(reg_addr(PBUS_TIM0_IDX, TIM_COUNT_REG), count, resp);
            check_resp("rresp", resp, PBUS_RESP_OKAY);
            check_bound("timer COUNT", count, load);
        end
        write_reg(PBUS_TIM0_IDX, TIM_STATUS_REG, 32'h1, 4'h1);     // unknown phase
        wait_irq(PBUS_TIM0_INTERRUPT, RELOAD_MAX + 10);
        write_reg(PBUS_TIM0_IDX, TIM_STATUS_REG, 32'h1, 4'h1);     // just after expiry
        tim_status_m[0] = 1'b0;
        @(negedge clk);
        check_irq("int_o", irq, expected_irq());
        wait_irq(PBUS_TIM0_INTERRUPT, RELOAD_MAX + 10);            // next period
        tim_status_m[0] = 1'b1;
        check_irq("int_o", irq, expected_irq());
        expect_reg(PBUS_TIM0_IDX, TIM_CTRL_REG, ctrl, "timer CTRL");
        write_reg(PBUS_TIM0_IDX, TIM_CTRL_REG, '0, 4'hF);          // stop first
        write_reg(PBUS_TIM0_IDX, TIM_STATUS_REG, 32'h1, 4'h1);
        tim_ctrl_m[0]   = '0;
        tim_status_m[0] = 1'b0;
        @(negedge clk);
        check_irq("int_o", irq, expected_irq());
    endtask

    //////////////////////////////
    // clock, watchdog, main
    //////////////////////////////
    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD/2) clk = ~clk;
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        report_failure("timeout, the test sequences did not finish in time");
    end

    initial begin
        seed      = 54;
        void'($urandom(seed));
        arst_n   <= 1'b0;
        axil_req <= '0;
        gpio_in  <= '0;
        reset_model();
        repeat (2) @(posedge clk);
        arst_n   <= 1'b1;
        @(negedge clk);
        check_irq("int_o", irq, '0);    // quiet out of reset
        verify_all_regs();
        run_gpio_out_test();
        run_illegal_test();
        run_gpio_in_test();
        run_oneshot_test();
        run_reload_test();
        $display("TEST OK");
        $finish;
    end

endmodule : tb_peripheral_bus
